// ==== source/dnoc_pkg.sv ====
`default_nettype none

package dnoc_pkg;

    // flit and memory word width used by the compute node
    localparam int DEFAULT_FLIT_WIDTH = 256;

    // words per ping or pong bank
    localparam int DEFAULT_BANK_DEPTH = 16;

    // which half of the ping-pong memory
    typedef enum logic {
        BANK_PING = 1'b0,
        BANK_PONG = 1'b1
    } bank_sel_e;

    // core-side reader
    typedef enum logic {
        RD_IDLE   = 1'b0,
        RD_STREAM = 1'b1
    } rd_state_e;

    // noc-side writer, fill means part of a packet is already stored
    typedef enum logic {
        WR_IDLE = 1'b0,
        WR_FILL = 1'b1
    } wr_state_e;

endpackage

`default_nettype wire

// ==== source/noc_in_writer.sv ====
`default_nettype none

module noc_in_writer #(
    parameter int  FLIT_WIDTH = dnoc_pkg::DEFAULT_FLIT_WIDTH,
    parameter int  BANK_DEPTH = dnoc_pkg::DEFAULT_BANK_DEPTH,
    localparam int ADDR_W     = $clog2(BANK_DEPTH),
    localparam int LEN_W      = ADDR_W + 1
) (
    input  wire                        clk,
    input  wire                        rst_i,

    input  wire  [FLIT_WIDTH-1:0]      node_out_flit_i,
    input  wire                        node_out_valid_i,
    input  wire                        node_out_last_i,
    input  wire  [1:0]                 bank_full_i,
    output logic                       node_out_ready_o,

    output logic                       wr_en_o,
    output dnoc_pkg::bank_sel_e        wr_bank_o,
    output logic [ADDR_W-1:0]          wr_addr_o,
    output logic [FLIT_WIDTH-1:0]      wr_data_o,
    output logic                       wr_done_o,
    output logic [LEN_W-1:0]           wr_len_o
);

    import dnoc_pkg::*;

    bank_sel_e          cur_bank;
    logic [LEN_W-1:0]   wr_cnt;
    logic               accept;

    // only stall when the bank we fill next is still owned by the reader
    // or while the node is held in reset
    assign node_out_ready_o = ~rst_i & ~bank_full_i[cur_bank];
    assign accept           = node_out_valid_i & node_out_ready_o;

    assign wr_en_o   = accept;
    assign wr_bank_o = cur_bank;
    assign wr_data_o = node_out_flit_i;
    // counter restarts at word 0 for every packet
    assign wr_addr_o = wr_cnt[ADDR_W-1:0];
    assign wr_done_o = accept & node_out_last_i;
    assign wr_len_o  = wr_cnt + LEN_W'(1);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cur_bank <= BANK_PING;
            wr_cnt   <= '0;
        end else if (accept) begin
            if (node_out_last_i) begin
                // packet closed, the other bank takes the next one
                wr_cnt   <= '0;
                cur_bank <= (cur_bank == BANK_PING) ? BANK_PONG : BANK_PING;
            end else begin
                wr_cnt <= wr_cnt + LEN_W'(1);
            end
        end
    end

    // a packet must fit in one bank
    a_pkt_fits_bank : assert property (
        @(posedge clk) disable iff (rst_i)
        accept |-> (wr_cnt < LEN_W'(BANK_DEPTH))
    );

endmodule

`default_nettype wire

// ==== source/pingpong_dmem.sv ====
`default_nettype none

module pingpong_dmem #(
    parameter int  FLIT_WIDTH = dnoc_pkg::DEFAULT_FLIT_WIDTH,
    parameter int  BANK_DEPTH = dnoc_pkg::DEFAULT_BANK_DEPTH,
    localparam int ADDR_W     = $clog2(BANK_DEPTH),
    localparam int LEN_W      = ADDR_W + 1
) (
    input  wire                        clk,
    input  wire                        rst_i,

    // write port from the noc side
    input  wire                        wr_en_i,
    input  wire dnoc_pkg::bank_sel_e   wr_bank_i,
    input  wire  [ADDR_W-1:0]          wr_addr_i,
    input  wire  [FLIT_WIDTH-1:0]      wr_data_i,
    input  wire                        wr_done_i,
    input  wire  [LEN_W-1:0]           wr_len_i,

    // read port toward the core
    input  wire                        rd_en_i,
    input  wire dnoc_pkg::bank_sel_e   rd_bank_i,
    input  wire  [ADDR_W-1:0]          rd_addr_i,
    input  wire                        rd_done_i,

    output logic [1:0]                 bank_full_o,
    output logic [1:0][LEN_W-1:0]      bank_len_o,
    output logic [FLIT_WIDTH-1:0]      rd_data_o
);

    import dnoc_pkg::*;

    logic [FLIT_WIDTH-1:0] mem_ping [BANK_DEPTH];
    logic [FLIT_WIDTH-1:0] mem_pong [BANK_DEPTH];

    // storage
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            if (wr_bank_i == BANK_PING) begin
                mem_ping[wr_addr_i] <= wr_data_i;
            end else begin
                mem_pong[wr_addr_i] <= wr_data_i;
            end
        end
    end

    // registered read, data valid one cycle after rd_en_i
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            if (rd_bank_i == BANK_PING) begin
                rd_data_o <= mem_ping[rd_addr_i];
            end else begin
                rd_data_o <= mem_pong[rd_addr_i];
            end
        end
    end

    // packet length is captured with the closing write
    always_ff @(posedge clk) begin
        if (wr_done_i) begin
            bank_len_o[wr_bank_i] <= wr_len_i;
        end
    end

    // full flag per bank, set by the writer and cleared by the reader
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bank_full_o <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (wr_done_i && (wr_bank_i == bank_sel_e'(b))) begin
                    bank_full_o[b] <= 1'b1;
                end else if (rd_done_i && (rd_bank_i == bank_sel_e'(b))) begin
                    bank_full_o[b] <= 1'b0;
                end
            end
        end
    end

    // writer only closes a packet into a free bank
    a_wr_done_free : assert property (
        @(posedge clk) disable iff (rst_i)
        wr_done_i |-> !bank_full_o[wr_bank_i]
    );

    // reader only releases a bank that holds a packet
    a_rd_done_full : assert property (
        @(posedge clk) disable iff (rst_i)
        rd_done_i |-> bank_full_o[rd_bank_i]
    );

endmodule

`default_nettype wire

// ==== source/core_rd_reader.sv ====
`default_nettype none

module core_rd_reader #(
    parameter int  FLIT_WIDTH = dnoc_pkg::DEFAULT_FLIT_WIDTH,
    parameter int  BANK_DEPTH = dnoc_pkg::DEFAULT_BANK_DEPTH,
    localparam int ADDR_W     = $clog2(BANK_DEPTH),
    localparam int LEN_W      = ADDR_W + 1
) (
    input  wire                        clk,
    input  wire                        rst_i,

    input  wire  [1:0]                 bank_full_i,
    input  wire  [1:0][LEN_W-1:0]      bank_len_i,
    input  wire  [FLIT_WIDTH-1:0]      rd_data_i,

    output logic                       rd_en_o,
    output dnoc_pkg::bank_sel_e        rd_bank_o,
    output logic [ADDR_W-1:0]          rd_addr_o,
    output logic                       rd_done_o,

    // core input, no ready on this side
    output logic [FLIT_WIDTH-1:0]      core_in_data_o,
    output logic                       core_in_valid_o,
    output logic                       core_in_last_o
);

    import dnoc_pkg::*;

    rd_state_e          state;
    bank_sel_e          cur_bank;
    logic [ADDR_W-1:0]  rd_addr;
    logic               rd_last;

    // final word of the stored packet
    assign rd_last = (LEN_W'(rd_addr) + LEN_W'(1)) == bank_len_i[cur_bank];

    assign rd_en_o   = (state == RD_STREAM);
    assign rd_bank_o = cur_bank;
    assign rd_addr_o = rd_addr;
    assign rd_done_o = (state == RD_STREAM) & rd_last;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= RD_IDLE;
            cur_bank <= BANK_PING;
            rd_addr  <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (bank_full_i[cur_bank]) begin
                        state   <= RD_STREAM;
                        rd_addr <= '0;
                    end
                end
                RD_STREAM: begin
                    if (rd_last) begin
                        // bank goes back to the writer, follow it to the other one
                        state    <= RD_IDLE;
                        cur_bank <= (cur_bank == BANK_PING) ? BANK_PONG : BANK_PING;
                    end else begin
                        rd_addr <= rd_addr + ADDR_W'(1);
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // strobes delayed to match the memory read latency
    always_ff @(posedge clk) begin
        if (rst_i) begin
            core_in_valid_o <= 1'b0;
            core_in_last_o  <= 1'b0;
        end else begin
            core_in_valid_o <= rd_en_o;
            core_in_last_o  <= rd_done_o;
        end
    end

    assign core_in_data_o = rd_data_i;

    // every read targets a bank that still holds its packet
    a_rd_from_full : assert property (
        @(posedge clk) disable iff (rst_i)
        rd_en_o |-> bank_full_i[cur_bank]
    );

endmodule

`default_nettype wire

// ==== source/cu_node_dnoc.sv ====
`default_nettype none

module cu_node_dnoc #(
    parameter int FLIT_WIDTH = dnoc_pkg::DEFAULT_FLIT_WIDTH,
    parameter int BANK_DEPTH = dnoc_pkg::DEFAULT_BANK_DEPTH
) (
    input  wire                    clk,
    input  wire                    rst_i,

    // noc data channel into the node
    input  wire  [FLIT_WIDTH-1:0]  node_out_flit_i,
    input  wire                    node_out_valid_i,
    input  wire                    node_out_last_i,
    output logic                   node_out_ready_o,

    // core input port, no back-pressure
    output logic [FLIT_WIDTH-1:0]  core_in_data_o,
    output logic                   core_in_valid_o,
    output logic                   core_in_last_o
);

    import dnoc_pkg::*;

    localparam int ADDR_W = $clog2(BANK_DEPTH);
    localparam int LEN_W  = ADDR_W + 1;

    // writer side
    logic                   wr_en;
    bank_sel_e              wr_bank;
    logic [ADDR_W-1:0]      wr_addr;
    logic [FLIT_WIDTH-1:0]  wr_data;
    logic                   wr_done;
    logic [LEN_W-1:0]       wr_len;

    // reader side
    logic                   rd_en;
    bank_sel_e              rd_bank;
    logic [ADDR_W-1:0]      rd_addr;
    logic                   rd_done;
    logic [FLIT_WIDTH-1:0]  rd_data;

    // bank status shared by both sides
    logic [1:0]             bank_full;
    logic [1:0][LEN_W-1:0]  bank_len;

    noc_in_writer #(
        .FLIT_WIDTH (FLIT_WIDTH),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_writer (
        .clk              (clk),
        .rst_i            (rst_i),
        .node_out_flit_i  (node_out_flit_i),
        .node_out_valid_i (node_out_valid_i),
        .node_out_last_i  (node_out_last_i),
        .bank_full_i      (bank_full),
        .node_out_ready_o (node_out_ready_o),
        .wr_en_o          (wr_en),
        .wr_bank_o        (wr_bank),
        .wr_addr_o        (wr_addr),
        .wr_data_o        (wr_data),
        .wr_done_o        (wr_done),
        .wr_len_o         (wr_len)
    );

    pingpong_dmem #(
        .FLIT_WIDTH (FLIT_WIDTH),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_dmem (
        .clk         (clk),
        .rst_i       (rst_i),
        .wr_en_i     (wr_en),
        .wr_bank_i   (wr_bank),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .wr_done_i   (wr_done),
        .wr_len_i    (wr_len),
        .rd_en_i     (rd_en),
        .rd_bank_i   (rd_bank),
        .rd_addr_i   (rd_addr),
        .rd_done_i   (rd_done),
        .bank_full_o (bank_full),
        .bank_len_o  (bank_len),
        .rd_data_o   (rd_data)
    );

    core_rd_reader #(
        .FLIT_WIDTH (FLIT_WIDTH),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_reader (
        .clk             (clk),
        .rst_i           (rst_i),
        .bank_full_i     (bank_full),
        .bank_len_i      (bank_len),
        .rd_data_i       (rd_data),
        .rd_en_o         (rd_en),
        .rd_bank_o       (rd_bank),
        .rd_addr_o       (rd_addr),
        .rd_done_o       (rd_done),
        .core_in_data_o  (core_in_data_o),
        .core_in_valid_o (core_in_valid_o),
        .core_in_last_o  (core_in_last_o)
    );

endmodule

`default_nettype wire

// ==== tests/dnoc_checker.sv ====
`default_nettype none

module dnoc_checker #(
    parameter int FLIT_WIDTH = 32,
    parameter int BANK_DEPTH = 16
) (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire                   node_out_valid_i,
    input  wire                   node_out_last_i,
    input  wire                   node_out_ready_i,
    input  wire  [FLIT_WIDTH-1:0] core_in_data_i,
    input  wire                   core_in_valid_i,
    input  wire                   core_in_last_i,
    input  wire  [FLIT_WIDTH-1:0] exp_core_i,
    input  wire                   done_i,
    output int                    core_idx_o = 0,
    output int                    lasts_seen_o = 0,
    output logic                  reported_o = 1'b0,
    output logic                  all_ok_o = 1'b0
);

    int     acc_cnt = 0;
    int     pkt_len = 0;
    int     n_pkts = 0;
    int     stall_cnt = 0;
    int     n_len1 = 0;
    int     n_len_full = 0;
    int     err_rst = 0;
    int     err_data = 0;
    int     err_last = 0;
    int     err_contig = 0;
    int     n_pass = 0;
    int     n_fail = 0;
    int     last_q[$];
    logic   rst_prev = 1'b0;
    logic   in_pkt = 1'b0;
    logic   is_end;

    task automatic report_mismatch(input string sig, input logic [FLIT_WIDTH-1:0] exp,
                                   input logic [FLIT_WIDTH-1:0] act);
        $display("[ERROR] t=%0t %s expected %0h got %0h", $time, sig, exp, act);
    endtask

    task automatic print_result(input string name, input int errs);
        if (errs == 0) begin
            $display("test %-16s PASS", name);
            n_pass++;
        end else begin
            $display("test %-16s FAIL (%0d errors)", name, errs);
            n_fail++;
        end
    endtask

    // everything sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (rst_i || rst_prev) begin
            if (core_in_valid_i) begin
                report_mismatch("core_in_valid_o", '0, FLIT_WIDTH'(core_in_valid_i));
                err_rst++;
            end
            if (core_in_last_i) begin
                report_mismatch("core_in_last_o", '0, FLIT_WIDTH'(core_in_last_i));
                err_rst++;
            end
        end
        if (rst_i && node_out_ready_i !== 1'b0) begin
            report_mismatch("node_out_ready_o", '0, FLIT_WIDTH'(node_out_ready_i));
            err_rst++;
        end
        if (rst_prev && !rst_i && !node_out_ready_i) begin
            report_mismatch("node_out_ready_o", FLIT_WIDTH'(1), '0);
            err_rst++;
        end
        rst_prev = rst_i;

        // noc side, a transfer happens on the coming edge
        if (!rst_i && node_out_valid_i) begin
            if (node_out_ready_i) begin
                pkt_len++;
                if (node_out_last_i) begin
                    last_q.push_back(acc_cnt);
                    n_pkts++;
                    if (pkt_len == 1) n_len1++;
                    if (pkt_len == BANK_DEPTH) n_len_full++;
                    pkt_len = 0;
                end
                acc_cnt++;
            end else begin
                stall_cnt++;
            end
        end

        // core side
        if (!rst_i) begin
            if (in_pkt && !core_in_valid_i) begin
                report_mismatch("core_in_valid_o", FLIT_WIDTH'(1), '0);
                err_contig++;
            end
            if (core_in_valid_i) begin
                if (core_in_data_i !== exp_core_i) begin
                    report_mismatch("core_in_data_o", exp_core_i, core_in_data_i);
                    err_data++;
                end
                is_end = (last_q.size() > 0) && (last_q[0] == core_idx_o);
                if (core_in_last_i !== is_end) begin
                    report_mismatch("core_in_last_o", FLIT_WIDTH'(is_end),
                                    FLIT_WIDTH'(core_in_last_i));
                    err_last++;
                end
                if (is_end) void'(last_q.pop_front());
                if (core_in_last_i) lasts_seen_o++;
                core_idx_o++;
            end else if (core_in_last_i) begin
                $display("core_in_last_o high without core_in_valid_o at t=%0t", $time);
                err_last++;
            end
            in_pkt = core_in_valid_i && !core_in_last_i;
        end

        if (done_i && !reported_o) begin
            if (core_idx_o != acc_cnt) begin
                $display("%0d flits accepted but %0d words delivered", acc_cnt, core_idx_o);
                err_data++;
            end
            if (lasts_seen_o != n_pkts || last_q.size() != 0) begin
                $display("%0d packets accepted but %0d last strobes", n_pkts, lasts_seen_o);
                err_last++;
            end
            if (stall_cnt == 0) begin
                $display("node_out_ready_o never dropped while a flit was waiting");
            end
            if (n_len1 < 3 || n_len_full < 3) begin
                $display("only %0d single-word and %0d full packets seen", n_len1, n_len_full);
            end
            print_result("reset", err_rst);
            print_result("data order", err_data);
            print_result("packet bounds", err_last);
            print_result("contiguous", err_contig);
            print_result("back-pressure", (stall_cnt > 0) ? err_data : 1);
            print_result("length extremes",
                         (n_len1 >= 3 && n_len_full >= 3) ? err_data + err_last + err_contig : 1);
            $display("tests passed %0d, failed %0d", n_pass, n_fail);
            all_ok_o   = (n_fail == 0);
            reported_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_cu_node_dnoc.sv ====
`default_nettype none

module tb_cu_node_dnoc;

    localparam int FLIT_WIDTH     = 32;
    localparam int BANK_DEPTH     = 16;
    localparam int NUM_PKTS       = 40;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * BANK_DEPTH * 4 + 200;

    logic                   clk;
    logic                   rst_i;
    logic [FLIT_WIDTH-1:0]  node_out_flit_i;
    logic                   node_out_valid_i;
    logic                   node_out_last_i;
    wire                    node_out_ready_o;
    wire  [FLIT_WIDTH-1:0]  core_in_data_o;
    wire                    core_in_valid_o;
    wire                    core_in_last_o;

    wire  [FLIT_WIDTH-1:0]  exp_core;
    int                     core_idx;
    int                     lasts_seen;
    logic                   reported;
    logic                   all_ok;
    logic                   done;
    int                     seed;
    int                     flit_idx;
    int                     cycle_cnt = 0;

    // reference word for the n-th accepted flit
    function automatic logic [FLIT_WIDTH-1:0] exp_flit(input int n);
        logic [FLIT_WIDTH-1:0] word;
        logic [31:0]           mix;
        word = '0;
        for (int c = 0; c < FLIT_WIDTH / 32; c++) begin
            mix = (32'(n) + 32'd1) * 32'h9e3779b1;
            mix = mix ^ (32'(c) * 32'h7f4a7c15);
            mix = mix ^ (mix >> 13);
            word[c*32 +: 32] = mix;
        end
        return word;
    endfunction

    function automatic int rand_between(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + int'($unsigned(r) % (hi - lo + 1));
    endfunction

    assign exp_core = exp_flit(core_idx);

    cu_node_dnoc #(
        .FLIT_WIDTH (FLIT_WIDTH),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_dut (
        .clk              (clk),
        .rst_i            (rst_i),
        .node_out_flit_i  (node_out_flit_i),
        .node_out_valid_i (node_out_valid_i),
        .node_out_last_i  (node_out_last_i),
        .node_out_ready_o (node_out_ready_o),
        .core_in_data_o   (core_in_data_o),
        .core_in_valid_o  (core_in_valid_o),
        .core_in_last_o   (core_in_last_o)
    );

    dnoc_checker #(
        .FLIT_WIDTH (FLIT_WIDTH),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_checker (
        .clk              (clk),
        .rst_i            (rst_i),
        .node_out_valid_i (node_out_valid_i),
        .node_out_last_i  (node_out_last_i),
        .node_out_ready_i (node_out_ready_o),
        .core_in_data_i   (core_in_data_o),
        .core_in_valid_i  (core_in_valid_o),
        .core_in_last_i   (core_in_last_o),
        .exp_core_i       (exp_core),
        .done_i           (done),
        .core_idx_o       (core_idx),
        .lasts_seen_o     (lasts_seen),
        .reported_o       (reported),
        .all_ok_o         (all_ok)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic idle_cycles(input int n);
        node_out_valid_i = 1'b0;
        node_out_last_i  = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // hold the flit until ready is seen mid-cycle before an edge
    task automatic send_flit(input logic last);
        logic taken;
        node_out_flit_i  = exp_flit(flit_idx);
        node_out_valid_i = 1'b1;
        node_out_last_i  = last;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = node_out_ready_o;
            @(posedge clk);
            #1;
        end
        flit_idx++;
    endtask

    // burst keeps valid high with no gaps
    task automatic send_packet(input int len, input logic burst);
        for (int i = 0; i < len; i++) begin
            if (!burst && rand_between(0, 3) == 0) begin
                idle_cycles(rand_between(1, 3));
            end
            send_flit(i == len - 1);
        end
    endtask

    initial begin
        int   len;
        logic burst;
        seed             = 32'h05b66526;
        rst_i            = 1'b1;
        node_out_flit_i  = '0;
        node_out_valid_i = 1'b0;
        node_out_last_i  = 1'b0;
        done             = 1'b0;
        flit_idx         = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_i = 1'b0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            // short packets back to back in the middle stretch
            burst = (p >= 20) && (p < 30);
            if (p % 10 == 3) begin
                len = 1;
            end else if (p % 10 == 7) begin
                len = BANK_DEPTH;
            end else if (burst) begin
                len = rand_between(1, 3);
            end else begin
                len = rand_between(1, BANK_DEPTH);
            end
            send_packet(len, burst);
        end
        idle_cycles(1);
        wait (lasts_seen == NUM_PKTS);
        idle_cycles(2);
        done = 1'b1;
        wait (reported);
        if (all_ok) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== cu_node_dnoc.f ====
source/dnoc_pkg.sv
source/noc_in_writer.sv
source/pingpong_dmem.sv
source/core_rd_reader.sv
source/cu_node_dnoc.sv
tests/dnoc_checker.sv
tests/tb_cu_node_dnoc.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cu_node_dnoc \
    -f cu_node_dnoc.f

out=$(./obj_dir/Vtb_cu_node_dnoc 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
